/* hw/sample_buf_pkg.sv */
`default_nettype none

package sample_buf_pkg;

    localparam int SAMPLE_WIDTH = 16;
    localparam int OFFSET_WIDTH = 10;   // 1024 samples.

    // control word layout.
    localparam int CTRL_RUN_BIT          = 0;
    localparam int CTRL_ONE_SHOT_BIT     = 1;
    localparam int CTRL_WAIT_TRIGGER_BIT = 2;

    typedef enum logic [1:0] {
        REG_START   = 2'd0,
        REG_END     = 2'd1,
        REG_CONTROL = 2'd2
    } csr_reg_e;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        ARMED   = 2'd1,
        PLAYING = 2'd2
    } play_state_e;

    typedef struct packed {
        logic                    en;
        csr_reg_e                reg_op;
        logic [OFFSET_WIDTH-1:0] data;      // offset or control bits.
    } reg_wr_t;

    typedef struct packed {
        logic                    en;
        logic [OFFSET_WIDTH-1:0] addr;
        logic [SAMPLE_WIDTH-1:0] data;
    } sample_wr_t;

    typedef struct packed {
        logic [OFFSET_WIDTH-1:0] start_offset;
        logic [OFFSET_WIDTH-1:0] end_offset;
        logic                    one_shot;
    } play_cfg_t;

    typedef struct packed {
        logic update;
        logic active;
    } play_cmd_t;

    typedef struct packed {
        logic                    valid;
        logic [SAMPLE_WIDTH-1:0] data;
    } sample_rd_t;

endpackage

`default_nettype wire

/* hw/sample_buf_csr.sv */
`default_nettype none

module sample_buf_csr (
    input  logic                    stream_out,
    input  logic                    reset,
    input  sample_buf_pkg::reg_wr_t reg_wr,
    input  logic                    trigger,
    input  logic                    stopped,
    output sample_buf_pkg::play_cfg_t cfg,
    output sample_buf_pkg::play_cmd_t cmd
);

    sample_buf_pkg::play_state_e state;

    logic ctrl_run;
    logic ctrl_one_shot;
    logic ctrl_wait_trigger;

    assign ctrl_run          = reg_wr.data[sample_buf_pkg::CTRL_RUN_BIT];
    assign ctrl_one_shot     = reg_wr.data[sample_buf_pkg::CTRL_ONE_SHOT_BIT];
    assign ctrl_wait_trigger = reg_wr.data[sample_buf_pkg::CTRL_WAIT_TRIGGER_BIT];

    always_ff @(posedge stream_out) begin
        if (reset) begin
            state            <= sample_buf_pkg::IDLE;
            cmd.update       <= 1'b0;
            cmd.active       <= 1'b0;
            cfg.start_offset <= '0;
            cfg.end_offset   <= '0;
            cfg.one_shot     <= 1'b0;
        end else begin
            cmd.update <= 1'b0;    // single cycle pulse.
            cmd.active <= 1'b0;

            // a register write below overrides these events.
            case (state)
                sample_buf_pkg::ARMED: begin
                    if (trigger) begin
                        state      <= sample_buf_pkg::PLAYING;
                        cmd.update <= 1'b1;
                        cmd.active <= 1'b1;
                    end
                end
                sample_buf_pkg::PLAYING: begin
                    if (stopped) begin
                        state <= sample_buf_pkg::IDLE;    // one-shot pass done.
                    end
                end
                default: begin
                end
            endcase

            if (reg_wr.en) begin
                case (reg_wr.reg_op)
                    sample_buf_pkg::REG_START: begin
                        cfg.start_offset <= reg_wr.data;
                    end
                    sample_buf_pkg::REG_END: begin
                        cfg.end_offset <= reg_wr.data;
                    end
                    sample_buf_pkg::REG_CONTROL: begin
                        cfg.one_shot <= ctrl_one_shot;
                        cmd.update   <= 1'b1;
                        if (ctrl_run && !ctrl_wait_trigger) begin
                            state      <= sample_buf_pkg::PLAYING;
                            cmd.active <= 1'b1;
                        end else if (ctrl_run) begin
                            // halt any current pass until the trigger.
                            state      <= sample_buf_pkg::ARMED;
                            cmd.active <= 1'b0;
                        end else begin
                            state      <= sample_buf_pkg::IDLE;
                            cmd.active <= 1'b0;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hw/sample_buf_ram.sv */
`default_nettype none

module sample_buf_ram (
    input  logic                                    stream_out,
    input  sample_buf_pkg::sample_wr_t              sample_wr,
    input  logic                                    rd_en,
    input  logic [sample_buf_pkg::OFFSET_WIDTH-1:0] rd_addr,
    output sample_buf_pkg::sample_rd_t              rd
);

    localparam int DEPTH = 2 ** sample_buf_pkg::OFFSET_WIDTH;

    logic [sample_buf_pkg::SAMPLE_WIDTH-1:0] mem [DEPTH];

    // host write port.
    always_ff @(posedge stream_out) begin
        if (sample_wr.en) begin
            mem[sample_wr.addr] <= sample_wr.data;
        end
    end

    // registered read with the valid flag alongside.
    always_ff @(posedge stream_out) begin
        rd.valid <= rd_en;
        if (rd_en) begin
            rd.data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* hw/playback_sequencer.sv */
`default_nettype none

module playback_sequencer (
    input  logic                                    stream_out,
    input  logic                                    reset,
    input  sample_buf_pkg::play_cfg_t               cfg,
    input  sample_buf_pkg::play_cmd_t               cmd,
    input  logic                                    room,
    output logic                                    rd_en,
    output logic [sample_buf_pkg::OFFSET_WIDTH-1:0] rd_addr,
    output logic                                    stopped,
    output logic                                    playing
);

    logic                                    enable;
    logic [sample_buf_pkg::OFFSET_WIDTH-1:0] addr;
    logic                                    at_end;

    // read only when the fifo can take the result.
    assign rd_en   = enable && room;
    assign rd_addr = addr;
    assign playing = enable;

    assign at_end = (addr >= cfg.end_offset);

    always_ff @(posedge stream_out) begin
        if (reset) begin
            enable  <= 1'b0;
            addr    <= '0;
            stopped <= 1'b0;
        end else begin
            stopped <= 1'b0;
            if (cmd.update) begin
                enable <= cmd.active;
                if (cmd.active) begin
                    addr <= cfg.start_offset;
                end
            end else if (rd_en) begin
                if (at_end && cfg.one_shot) begin
                    enable  <= 1'b0;    // last sample of the pass.
                    stopped <= 1'b1;
                end else if (at_end) begin
                    addr <= cfg.start_offset;
                end else begin
                    addr <= addr + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/playback_fifo.sv */
`default_nettype none

module playback_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                    stream_out,
    input  logic                                    reset,
    input  logic                                    rd_issue,
    input  sample_buf_pkg::sample_rd_t              rd,
    output logic                                    room,
    output logic [sample_buf_pkg::SAMPLE_WIDTH-1:0] out_data,
    output logic                                    out_valid,
    input  logic                                    out_ready
);

    localparam int PTR_W   = $clog2(FIFO_DEPTH);
    localparam int COUNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [COUNT_W:0] DEPTH_LIMIT = (COUNT_W + 1)'(FIFO_DEPTH);

    logic [sample_buf_pkg::SAMPLE_WIDTH-1:0] mem [FIFO_DEPTH];

    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [COUNT_W-1:0] count;
    logic [COUNT_W-1:0] in_flight;  // reads issued but not yet returned.
    logic [COUNT_W:0]   used;
    logic               push;
    logic               pop;

    assign push = rd.valid;
    assign pop  = out_valid && out_ready;

    assign used = {1'b0, count} + {1'b0, in_flight};
    assign room = (used < DEPTH_LIMIT);

    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge stream_out) begin
        if (push) begin
            mem[wr_ptr] <= rd.data;
        end
    end

    always_ff @(posedge stream_out) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_flight <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (!push && pop) begin
                count <= count - 1'b1;
            end

            // a returning read converts one credit into a stored sample.
            if (rd_issue && !rd.valid) begin
                in_flight <= in_flight + 1'b1;
            end else if (!rd_issue && rd.valid) begin
                in_flight <= in_flight - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/sample_buffer_out.sv */
`default_nettype none

module sample_buffer_out #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                    stream_out,
    input  logic                                    reset,
    input  sample_buf_pkg::sample_wr_t              sample_wr,
    input  sample_buf_pkg::reg_wr_t                 reg_wr,
    input  logic                                    trigger,
    output logic [sample_buf_pkg::SAMPLE_WIDTH-1:0] out_data,
    output logic                                    out_valid,
    input  logic                                    out_ready,
    output logic                                    playing
);

    sample_buf_pkg::play_cfg_t               cfg;
    sample_buf_pkg::play_cmd_t               cmd;
    sample_buf_pkg::sample_rd_t              rd;
    logic                                    stopped;
    logic                                    rd_en;
    logic [sample_buf_pkg::OFFSET_WIDTH-1:0] rd_addr;
    logic                                    room;

    sample_buf_csr u_csr (
        .stream_out (stream_out),
        .reset      (reset),
        .reg_wr     (reg_wr),
        .trigger    (trigger),
        .stopped    (stopped),
        .cfg        (cfg),
        .cmd        (cmd)
    );

    sample_buf_ram u_ram (
        .stream_out (stream_out),
        .sample_wr  (sample_wr),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd         (rd)
    );

    playback_sequencer u_sequencer (
        .stream_out (stream_out),
        .reset      (reset),
        .cfg        (cfg),
        .cmd        (cmd),
        .room       (room),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .stopped    (stopped),
        .playing    (playing)
    );

    // credits cover the one-cycle ram latency.
    playback_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .stream_out (stream_out),
        .reset      (reset),
        .rd_issue   (rd_en),
        .rd         (rd),
        .room       (room),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

/* test/sample_buffer_out_checker.sv */
`default_nettype none

module sample_buffer_out_checker #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                    stream_out,
    input  logic                                    reset,
    input  sample_buf_pkg::sample_wr_t              sample_wr,
    input  sample_buf_pkg::reg_wr_t                 reg_wr,
    input  logic                                    trigger,
    input  logic [sample_buf_pkg::SAMPLE_WIDTH-1:0] out_data,
    input  logic                                    out_valid,
    input  logic                                    out_ready,
    input  logic                                    playing,
    input  logic [2:0]                              test_id,
    input  logic                                    test_start,
    input  logic                                    test_done,
    input  logic                                    quiet,
    input  int                                      exp_count,
    input  logic                                    report,
    output int                                      xfer_count,
    output int                                      error_count
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [sample_buf_pkg::SAMPLE_WIDTH-1:0] mem_model [2 ** sample_buf_pkg::OFFSET_WIDTH];
    logic [sample_buf_pkg::OFFSET_WIDTH-1:0] start_offset;
    logic [sample_buf_pkg::OFFSET_WIDTH-1:0] end_offset;
    logic [sample_buf_pkg::OFFSET_WIDTH-1:0] next_addr;
    logic [sample_buf_pkg::SAMPLE_WIDTH-1:0] held_data;
    logic one_shot;
    logic armed;
    logic seq_idle;     // no pass running in the model.
    logic held;
    int drained;
    int test_errors;
    int tests_run;
    int tests_failed;
    string name;

    function automatic string test_label(input logic [2:0] id);
        case (id)
            3'd0: return "loop_playback";
            3'd1: return "one_shot";
            3'd2: return "trigger_arming";
            3'd3: return "stop";
            default: return "back_pressure";
        endcase
    endfunction

    task automatic value_error(input string what, input logic [15:0] expected,
                               input logic [15:0] actual);
        $display("error %s %s expected %h actual %h", name, what, expected, actual);
        test_errors++;
        error_count++;
    endtask

    task automatic count_error(input string what, input int expected, input int actual);
        $display("error %s %s expected %0d actual %0d", name, what, expected, actual);
        test_errors++;
        error_count++;
    endtask

    task automatic plain_error(input string what);
        $display("%s: %s", name, what);
        test_errors++;
        error_count++;
    endtask

    always @(posedge stream_out) begin
        if (reset) begin
            armed        = 1'b0;
            seq_idle     = 1'b1;
            held         = 1'b0;
            one_shot     = 1'b0;
            start_offset = '0;
            end_offset   = '0;
            next_addr    = '0;
            xfer_count   = 0;
            error_count  = 0;
            drained      = 0;
            test_errors  = 0;
            tests_run    = 0;
            tests_failed = 0;
            name         = "none";
        end else begin
            if (test_start) begin
                name        = test_label(test_id);
                xfer_count  = 0;
                drained     = 0;
                test_errors = 0;
            end

            if (held) begin
                if (!out_valid) begin
                    plain_error("out_valid dropped while out_ready was low");
                end else if (out_data !== held_data) begin
                    value_error("held data", held_data, out_data);
                end
            end
            held      = out_valid && !out_ready;
            held_data = out_data;

            if (out_valid && out_ready) begin
                xfer_count++;
                if (!playing) begin
                    drained++;  // left over after the sequencer stopped.
                end
                if (seq_idle) begin
                    plain_error("a sample arrived although no pass was running");
                end else begin
                    if (out_data !== mem_model[next_addr]) begin
                        value_error("sample", mem_model[next_addr], out_data);
                    end
                    if (next_addr >= end_offset) begin
                        if (one_shot) begin
                            seq_idle = 1'b1;
                        end else begin
                            next_addr = start_offset;
                        end
                    end else begin
                        next_addr = next_addr + 1'b1;
                    end
                end
            end

            if (quiet && (out_valid || playing)) begin
                plain_error("out_valid or playing went high while the buffer should be idle");
            end

            if (sample_wr.en) begin
                mem_model[sample_wr.addr] = sample_wr.data;
            end
            if (trigger && armed) begin
                armed     = 1'b0;
                seq_idle  = 1'b0;
                next_addr = start_offset;
            end
            if (reg_wr.en) begin
                case (reg_wr.reg_op)
                    sample_buf_pkg::REG_START: start_offset = reg_wr.data;
                    sample_buf_pkg::REG_END: end_offset = reg_wr.data;
                    sample_buf_pkg::REG_CONTROL: begin
                        one_shot = reg_wr.data[sample_buf_pkg::CTRL_ONE_SHOT_BIT];
                        armed    = 1'b0;
                        if (reg_wr.data[sample_buf_pkg::CTRL_RUN_BIT]) begin
                            if (reg_wr.data[sample_buf_pkg::CTRL_WAIT_TRIGGER_BIT]) begin
                                armed = 1'b1;
                            end else begin
                                seq_idle  = 1'b0;
                                next_addr = start_offset;
                            end
                        end
                    end
                    default: begin
                    end
                endcase
            end

            if (test_done) begin
                if (exp_count >= 0 && xfer_count != exp_count) begin
                    count_error("transfer count", exp_count, xfer_count);
                end
                if (drained > FIFO_DEPTH) begin
                    count_error("drained samples at most", FIFO_DEPTH, drained);
                end
                tests_run++;
                if (test_errors != 0) begin
                    tests_failed++;
                end
                $display("test %s: %s, %0d transfers, %0d errors", name,
                         (test_errors == 0) ? "ok" : "failed", xfer_count, test_errors);
            end
            if (report) begin
                $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                         error_count);
            end
        end
    end

endmodule

`default_nettype wire

/* test/sample_buffer_out_tb.sv */
`default_nettype none

module sample_buffer_out_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FIFO_DEPTH = 8;
    localparam int WAIT_LIMIT = 20000;

    logic                                    stream_out;
    logic                                    reset;
    sample_buf_pkg::sample_wr_t              sample_wr;
    sample_buf_pkg::reg_wr_t                 reg_wr;
    logic                                    trigger;
    logic [sample_buf_pkg::SAMPLE_WIDTH-1:0] out_data;
    logic                                    out_valid;
    logic                                    out_ready;
    logic                                    playing;

    logic [2:0] test_id;
    logic       test_start;
    logic       test_done;
    logic       quiet;
    logic       report;
    int         exp_count;
    int         xfer_count;
    int         error_count;

    logic ready_random;
    logic stall_mode;
    int   stall_left;
    int   seed;
    int   span;
    logic [sample_buf_pkg::OFFSET_WIDTH-1:0] start_off;
    logic [sample_buf_pkg::OFFSET_WIDTH-1:0] end_off;
    event  abort_ev;
    string abort_reason;

    sample_buffer_out #(.FIFO_DEPTH(FIFO_DEPTH)) u_sample_buffer_out (
        .stream_out (stream_out), .reset (reset), .sample_wr (sample_wr), .reg_wr (reg_wr),
        .trigger (trigger), .out_data (out_data), .out_valid (out_valid),
        .out_ready (out_ready), .playing (playing)
    );

    sample_buffer_out_checker #(.FIFO_DEPTH(FIFO_DEPTH)) u_checker (
        .stream_out (stream_out), .reset (reset), .sample_wr (sample_wr), .reg_wr (reg_wr),
        .trigger (trigger), .out_data (out_data), .out_valid (out_valid),
        .out_ready (out_ready), .playing (playing), .test_id (test_id),
        .test_start (test_start), .test_done (test_done), .quiet (quiet),
        .exp_count (exp_count), .report (report), .xfer_count (xfer_count),
        .error_count (error_count)
    );

    initial stream_out = 1'b0;
    always #5 stream_out = ~stream_out;

    task automatic update_ready();
        logic [31:0] r;
        r = $random(seed);
        if (stall_left > 0) begin
            out_ready = 1'b0;
            stall_left--;
        end else if (stall_mode && r[2:0] == 3'd0) begin
            stall_left = int'(r[15:8] % 8'd40);    // low for 1 to 40 cycles.
            out_ready  = 1'b0;
        end else if (ready_random) begin
            out_ready = (r[1:0] != 2'b00);
        end else begin
            out_ready = 1'b1;
        end
    endtask

    task automatic tick();
        @(posedge stream_out);
        #1;
        update_ready();
    endtask

    task automatic give_up(input string what);
        abort_reason = what;
        -> abort_ev;
        forever @(posedge stream_out);    // the abort process ends the run.
    endtask

    task automatic write_sample(input logic [9:0] addr, input logic [15:0] data);
        sample_wr.en   = 1'b1;
        sample_wr.addr = addr;
        sample_wr.data = data;
        tick();
        sample_wr.en = 1'b0;
    endtask

    task automatic write_reg(input sample_buf_pkg::csr_reg_e op, input logic [9:0] data);
        reg_wr.en     = 1'b1;
        reg_wr.reg_op = op;
        reg_wr.data   = data;
        tick();
        reg_wr.en = 1'b0;
    endtask

    task automatic control(input logic run, input logic one_shot, input logic wait_trig);
        logic [sample_buf_pkg::OFFSET_WIDTH-1:0] d;
        d = '0;
        d[sample_buf_pkg::CTRL_RUN_BIT]          = run;
        d[sample_buf_pkg::CTRL_ONE_SHOT_BIT]     = one_shot;
        d[sample_buf_pkg::CTRL_WAIT_TRIGGER_BIT] = wait_trig;
        write_reg(sample_buf_pkg::REG_CONTROL, d);
    endtask

    task automatic pick_range();
        logic [31:0] r;
        r = $random(seed);
        start_off = {1'b0, r[8:0]};
        span      = 1 + int'(r[21:16]);
        end_off   = start_off + 10'(span - 1);
        write_reg(sample_buf_pkg::REG_START, start_off);
        write_reg(sample_buf_pkg::REG_END, end_off);
    endtask

    task automatic begin_test(input logic [2:0] id, input int expected);
        test_id    = id;
        exp_count  = expected;
        test_start = 1'b1;
        tick();
        test_start = 1'b0;
    endtask

    task automatic end_test();
        test_done = 1'b1;
        tick();
        test_done = 1'b0;
    endtask

    task automatic wait_playing(input logic level, input string what);
        int i;
        i = 0;
        while (playing !== level && i < WAIT_LIMIT) begin
            tick();
            i++;
        end
        if (playing !== level) give_up(what);
    endtask

    task automatic wait_transfers(input int n, input string what);
        int i;
        i = 0;
        while (xfer_count < n && i < WAIT_LIMIT) begin
            tick();
            i++;
        end
        if (xfer_count < n) give_up(what);
    endtask

    task automatic wait_drained();
        int i;
        int idle;
        i    = 0;
        idle = 0;
        while (idle < 4 && i < WAIT_LIMIT) begin
            tick();
            i++;
            idle = (out_valid || playing) ? 0 : idle + 1;
        end
        if (idle < 4) give_up("The output stream did not drain after playback stopped.");
    endtask

    task automatic hold_quiet(input int n);
        quiet = 1'b1;
        repeat (n) tick();
        quiet = 1'b0;
    endtask

    initial begin
        @(abort_ev);
        $display("%s", abort_reason);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        logic [31:0] r;
        int n;
        seed = 36;
        reset = 1'b1;
        sample_wr = '0;
        reg_wr = '0;
        trigger = 1'b0;
        out_ready = 1'b0;
        test_id = '0;
        test_start = 1'b0;
        test_done = 1'b0;
        quiet = 1'b0;
        report = 1'b0;
        exp_count = -1;
        ready_random = 1'b0;
        stall_mode = 1'b0;
        stall_left = 0;
        repeat (4) @(posedge stream_out);
        #1;
        reset = 1'b0;
        tick();

        begin_test(3'd0, -1);
        for (int a = 0; a < 1024; a++) begin
            r = $random(seed);
            write_sample(a[9:0], r[15:0]);
        end
        pick_range();
        ready_random = 1'b1;
        control(1'b1, 1'b0, 1'b0);
        wait_transfers(3 * span, "Three loop passes did not complete in time.");
        control(1'b0, 1'b0, 1'b0);
        wait_playing(1'b0, "Playing did not go low after the run bit was cleared.");
        wait_drained();
        end_test();

        pick_range();
        begin_test(3'd1, span);
        control(1'b1, 1'b1, 1'b0);
        wait_playing(1'b1, "Playing did not go high for the one-shot pass.");
        wait_playing(1'b0, "Playing did not go low at the end of the one-shot pass.");
        wait_drained();
        hold_quiet(50);
        end_test();

        pick_range();
        begin_test(3'd2, -1);
        control(1'b1, 1'b0, 1'b1);
        hold_quiet(30);
        trigger = 1'b1;
        tick();
        trigger = 1'b0;
        wait_transfers(2 * span, "Playback did not run after the trigger pulse.");
        control(1'b0, 1'b0, 1'b0);
        wait_playing(1'b0, "Playing did not go low after the run bit was cleared.");
        wait_drained();
        end_test();

        pick_range();
        begin_test(3'd3, -1);
        control(1'b1, 1'b0, 1'b0);
        r = $random(seed);
        n = 1 + int'(r[7:0]) % (2 * span);
        wait_transfers(n, "Loop playback stalled before the stop.");
        control(1'b0, 1'b0, 1'b0);
        wait_playing(1'b0, "Playing did not go low after the stop write.");
        wait_drained();
        end_test();

        pick_range();
        begin_test(3'd4, -1);
        stall_mode = 1'b1;
        control(1'b1, 1'b0, 1'b0);
        wait_transfers(3 * span + 40, "Playback stalled under back-pressure.");
        control(1'b0, 1'b0, 1'b0);
        stall_mode = 1'b0;
        wait_playing(1'b0, "Playing did not go low after the run bit was cleared.");
        wait_drained();
        end_test();

        report = 1'b1;
        tick();
        report = 1'b0;
        tick();
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sample_buffer_out.f */
hw/sample_buf_pkg.sv
hw/sample_buf_csr.sv
hw/sample_buf_ram.sv
hw/playback_sequencer.sv
hw/playback_fifo.sv
hw/sample_buffer_out.sv
test/sample_buffer_out_checker.sv
test/sample_buffer_out_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= sample_buffer_out_tb
FILELIST  ?= sample_buffer_out.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
